/* design/gobou_pkg.sv */
package gobou_pkg;

  // ==============================
  // sizes
  // ==============================

  // neuron cores and width of a core select
  localparam int GOBOU_CORE    = 4;
  localparam int GOBOU_CORELOG = 2;

  // address widths of net and image memories
  localparam int GOBOU_NETSIZE = 8;
  localparam int IMGSIZE       = 10;

  // layer neuron counts
  localparam int LWIDTH = 10;

  // data words and accumulator
  localparam int DWIDTH = 16;
  localparam int AWIDTH = 40;

  // ==============================
  // fixed point
  // ==============================

  // fraction bits of data, weights and biases
  localparam int FRAC = 8;

  typedef logic signed [DWIDTH-1:0] data_t;
  typedef logic signed [AWIDTH-1:0] acc_t;
  typedef data_t [GOBOU_CORE-1:0]   core_data_t;
  typedef logic [IMGSIZE-1:0]       img_addr_t;
  typedef logic [GOBOU_NETSIZE-1:0] net_addr_t;
  typedef logic [LWIDTH-1:0]        lcount_t;
  typedef logic [GOBOU_CORELOG-1:0] core_sel_t;

  // output neurons handled per group
  localparam lcount_t CORE_STEP = lcount_t'(GOBOU_CORE);

  // saturation bounds in accumulator width
  localparam acc_t SAT_MAX = acc_t'((1 << (DWIDTH - 1)) - 1);
  localparam acc_t SAT_MIN = -acc_t'(1 << (DWIDTH - 1));

  // strobes between sequencer and cores
  typedef struct packed {
    logic start;
    logic valid;
    logic stop;
  } ctrl_reg;

endpackage

/* design/gobou_mem.sv */
`timescale 1ns/1ps

module gobou_mem #(
  parameter int DEPTH_LOG = 8,
  parameter int WIDTH     = 16
) (
  input  logic                 clk,
  input  logic                 we,
  input  logic [DEPTH_LOG-1:0] addr,
  input  logic [WIDTH-1:0]     wdata,
  output logic [WIDTH-1:0]     rdata
);

  logic [WIDTH-1:0] ram [0:(1 << DEPTH_LOG)-1];

  // read returns the old word on a write to the same address
  always_ff @(posedge clk) begin
    if (we) begin
      ram[addr] <= wdata;
    end
    rdata <= ram[addr];
  end

endmodule

/* design/gobou_core.sv */
`timescale 1ns/1ps

module gobou_core (
  input  logic               clk,
  input  logic               xrst,
  input  gobou_pkg::ctrl_reg in_ctrl,
  input  logic               breg_we,
  input  gobou_pkg::data_t   img_rdata,
  input  gobou_pkg::data_t   net_rdata,
  output gobou_pkg::ctrl_reg out_ctrl,
  output gobou_pkg::data_t   result
);

  logic               r_term_en;
  logic               r_last;
  gobou_pkg::acc_t    r_term;
  gobou_pkg::acc_t    r_acc;
  gobou_pkg::data_t   r_result;
  gobou_pkg::ctrl_reg r_out_ctrl;
  gobou_pkg::acc_t    sum;
  gobou_pkg::acc_t    scaled;

  // clamp to the signed data range
  function automatic gobou_pkg::data_t saturate(input gobou_pkg::acc_t v);
    if (v > gobou_pkg::SAT_MAX) begin
      return gobou_pkg::data_t'(gobou_pkg::SAT_MAX);
    end else if (v < gobou_pkg::SAT_MIN) begin
      return gobou_pkg::data_t'(gobou_pkg::SAT_MIN);
    end
    return gobou_pkg::data_t'(v);
  endfunction

  // stage 1: product term or bias aligned to the fixed point
  always_ff @(posedge clk) begin
    if (in_ctrl.valid) begin
      r_term <= gobou_pkg::acc_t'(img_rdata) * gobou_pkg::acc_t'(net_rdata);
    end else if (breg_we) begin
      r_term <= gobou_pkg::acc_t'(net_rdata) <<< gobou_pkg::FRAC;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_term_en <= 1'b0;
      r_last    <= 1'b0;
    end else begin
      r_term_en <= in_ctrl.valid || breg_we;
      r_last    <= in_ctrl.stop;
    end
  end

  // stage 2: accumulate
  assign sum    = r_acc + r_term;
  // arithmetic shift rounds toward minus infinity
  assign scaled = sum >>> gobou_pkg::FRAC;

  always_ff @(posedge clk) begin
    if (in_ctrl.start) begin
      r_acc <= '0;
    end else if (r_term_en) begin
      r_acc <= sum;
    end
    if (r_last) begin
      r_result <= saturate(scaled);
    end
  end

  // result strobe, two cycles after stop
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_out_ctrl <= '0;
    end else begin
      r_out_ctrl.start <= r_last;
      r_out_ctrl.valid <= r_last;
      r_out_ctrl.stop  <= 1'b0;
    end
  end

  assign out_ctrl = r_out_ctrl;
  assign result   = r_result;

endmodule

/* design/gobou_serial.sv */
`timescale 1ns/1ps

module gobou_serial (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  serial_we,
  input  gobou_pkg::core_data_t in_data,
  output gobou_pkg::data_t      out_data
);

  // word 0 sits at the output end
  gobou_pkg::core_data_t r_buf;

  // parallel load, then one word down per cycle
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_buf <= '0;
    end else if (serial_we) begin
      r_buf <= in_data;
    end else begin
      r_buf <= {gobou_pkg::data_t'(0), r_buf[gobou_pkg::GOBOU_CORE-1:1]};
    end
  end

  assign out_data = r_buf[0];

endmodule

/* design/gobou_img_arb.sv */
`timescale 1ns/1ps

module gobou_img_arb (
  input  logic                 clk,
  input  logic                 xrst,
  input  logic                 busy,
  input  logic                 host_en,
  input  logic                 host_we,
  input  gobou_pkg::img_addr_t host_addr,
  input  gobou_pkg::data_t     host_wdata,
  input  logic                 seq_we,
  input  gobou_pkg::img_addr_t seq_addr,
  input  gobou_pkg::data_t     seq_wdata,
  output logic                 host_gnt,
  output logic                 mem_we,
  output gobou_pkg::img_addr_t mem_addr,
  output gobou_pkg::data_t     mem_wdata
);

  // port owner of the previous cycle, 1 for the sequencer
  logic r_seq_owner;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_seq_owner <= 1'b0;
    end else if (r_seq_owner != busy) begin
      r_seq_owner <= busy;
    end
  end

  // host waits one idle cycle so the last sequencer read drains first
  assign host_gnt = !busy && !r_seq_owner;

  // ungranted host writes are dropped
  assign mem_we    = host_gnt ? host_en && host_we : seq_we;
  assign mem_addr  = host_gnt ? host_addr : seq_addr;
  assign mem_wdata = host_gnt ? host_wdata : seq_wdata;

endmodule

/* design/gobou_ctrl_core.sv */
`timescale 1ns/1ps

module gobou_ctrl_core (
  input  logic                  clk,
  input  logic                  xrst,
  input  gobou_pkg::ctrl_reg    in_ctrl,
  input  logic                  req,
  input  gobou_pkg::core_sel_t  net_sel,
  input  logic                  net_we,
  input  gobou_pkg::net_addr_t  net_addr,
  input  gobou_pkg::img_addr_t  in_offset,
  input  gobou_pkg::img_addr_t  out_offset,
  input  gobou_pkg::lcount_t    total_out,
  input  gobou_pkg::lcount_t    total_in,
  input  gobou_pkg::data_t      out_wdata,
  output gobou_pkg::ctrl_reg    out_ctrl,
  output logic                  ack,
  output logic                  img_we,
  output gobou_pkg::img_addr_t  img_addr,
  output gobou_pkg::data_t      img_wdata,
  output logic [gobou_pkg::GOBOU_CORE-1:0] mem_net_we,
  output gobou_pkg::net_addr_t  mem_net_addr,
  output logic                  breg_we,
  output logic                  serial_we
);

  typedef enum logic [1:0] {
    S_WAIT,
    S_WEIGHT,
    S_BIAS,
    S_OUTPUT
  } state_t;

  state_t               r_state;
  gobou_pkg::ctrl_reg   r_out_ctrl;
  logic                 r_ack;
  gobou_pkg::lcount_t   r_total_in;
  gobou_pkg::lcount_t   r_total_out;
  gobou_pkg::lcount_t   r_count_in;
  gobou_pkg::lcount_t   r_count_out;
  gobou_pkg::lcount_t   r_serial_cnt;
  gobou_pkg::img_addr_t r_in_offset;
  gobou_pkg::img_addr_t r_out_offset;
  gobou_pkg::img_addr_t r_input_addr;
  gobou_pkg::img_addr_t r_output_addr;
  gobou_pkg::net_addr_t r_net_offset;
  gobou_pkg::net_addr_t r_net_addr;
  logic                 r_img_we;
  logic                 r_breg_we;
  logic                 r_serial_we;

  logic accept;
  logic last_group;
  logic s_weight_end;
  logic s_bias_end;
  logic s_output_end;

  // requests only count while idle
  assign accept       = req && r_ack;
  assign last_group   = r_count_out + gobou_pkg::CORE_STEP >= r_total_out;
  assign s_weight_end = r_state == S_WEIGHT
                        && r_count_in == r_total_in - gobou_pkg::lcount_t'(1);
  assign s_bias_end   = r_state == S_BIAS;
  assign s_output_end = r_state == S_OUTPUT && r_serial_cnt == gobou_pkg::CORE_STEP;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state     <= S_WAIT;
      r_count_in  <= '0;
      r_count_out <= '0;
    end else begin
      case (r_state)
        S_WAIT: begin
          if (accept) begin
            r_state     <= S_WEIGHT;
            r_count_in  <= '0;
            r_count_out <= '0;
          end
        end
        S_WEIGHT: begin
          if (s_weight_end) begin
            r_state    <= S_BIAS;
            r_count_in <= '0;
          end else begin
            r_count_in <= r_count_in + gobou_pkg::lcount_t'(1);
          end
        end
        S_BIAS: begin
          r_state <= S_OUTPUT;
        end
        S_OUTPUT: begin
          // next group or back to idle once all words are out
          if (s_output_end) begin
            if (last_group) begin
              r_state <= S_WAIT;
            end else begin
              r_state     <= S_WEIGHT;
              r_count_out <= r_count_out + gobou_pkg::CORE_STEP;
            end
          end
        end
        default: begin
          r_state <= S_WAIT;
        end
      endcase
    end
  end

  // layer geometry held for the whole request
  always_ff @(posedge clk) begin
    if (accept) begin
      r_total_in   <= total_in;
      r_total_out  <= total_out;
      r_in_offset  <= in_offset;
      r_out_offset <= out_offset;
      r_net_offset <= net_addr;
    end
  end

  // ==============================
  // image side
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_img_we      <= 1'b0;
      r_input_addr  <= '0;
      r_output_addr <= '0;
    end else begin
      // one write per serializer word
      r_img_we <= r_state == S_OUTPUT
                  && (r_serial_we
                      || (r_serial_cnt != '0 && r_serial_cnt < gobou_pkg::CORE_STEP));
      if (s_bias_end) begin
        r_input_addr <= '0;
      end else if (r_state == S_WEIGHT && !s_weight_end) begin
        r_input_addr <= r_input_addr + gobou_pkg::img_addr_t'(1);
      end
      // runs across groups within one request
      if (accept) begin
        r_output_addr <= '0;
      end else if (r_img_we) begin
        r_output_addr <= r_output_addr + gobou_pkg::img_addr_t'(1);
      end
    end
  end

  assign img_we    = r_img_we;
  assign img_addr  = (r_state == S_OUTPUT) ? r_out_offset + r_output_addr
                                           : r_in_offset + r_input_addr;
  assign img_wdata = (r_state == S_OUTPUT) ? out_wdata : '0;

  // ==============================
  // net side
  // ==============================

  // host writes decoded per core
  for (genvar i = 0; i < gobou_pkg::GOBOU_CORE; i++) begin : g_net_we
    assign mem_net_we[i] = net_we && net_sel == gobou_pkg::core_sel_t'(i);
  end

  // weights then bias, contiguous for every group
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_net_addr <= '0;
    end else if (accept) begin
      r_net_addr <= '0;
    end else if (r_state == S_WEIGHT || r_state == S_BIAS) begin
      r_net_addr <= r_net_addr + gobou_pkg::net_addr_t'(1);
    end
  end

  assign mem_net_addr = net_we ? net_addr : r_net_offset + r_net_addr;

  // ==============================
  // strobes and handshake
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_out_ctrl   <= '0;
      r_breg_we    <= 1'b0;
      r_serial_we  <= 1'b0;
      r_serial_cnt <= '0;
      r_ack        <= 1'b1;
    end else begin
      // registered so they meet the memory read data
      r_out_ctrl.start <= accept || (s_output_end && !last_group);
      r_out_ctrl.valid <= r_state == S_WEIGHT;
      r_out_ctrl.stop  <= s_bias_end;
      r_breg_we        <= s_bias_end;
      // core 0 speaks for all cores
      r_serial_we      <= in_ctrl.start;
      if (r_serial_we) begin
        r_serial_cnt <= gobou_pkg::lcount_t'(1);
      end else if (r_serial_cnt == gobou_pkg::CORE_STEP) begin
        r_serial_cnt <= '0;
      end else if (r_serial_cnt != '0) begin
        r_serial_cnt <= r_serial_cnt + gobou_pkg::lcount_t'(1);
      end
      if (accept) begin
        r_ack <= 1'b0;
      end else if (s_output_end && last_group) begin
        r_ack <= 1'b1;
      end
    end
  end

  assign out_ctrl  = r_out_ctrl;
  assign breg_we   = r_breg_we;
  assign serial_we = r_serial_we;
  assign ack       = r_ack;

endmodule

/* design/gobou_top.sv */
`timescale 1ns/1ps

module gobou_top (
  input  logic                 clk,
  input  logic                 xrst,
  input  logic                 req,
  input  gobou_pkg::img_addr_t in_offset,
  input  gobou_pkg::img_addr_t out_offset,
  input  gobou_pkg::lcount_t   total_in,
  input  gobou_pkg::lcount_t   total_out,
  input  logic                 net_we,
  input  gobou_pkg::core_sel_t net_sel,
  input  gobou_pkg::net_addr_t net_addr,
  input  gobou_pkg::data_t     net_wdata,
  input  logic                 host_img_en,
  input  logic                 host_img_we,
  input  gobou_pkg::img_addr_t host_img_addr,
  input  gobou_pkg::data_t     host_img_wdata,
  output logic                 ack,
  output logic                 host_img_gnt,
  output gobou_pkg::data_t     host_img_rdata
);

  gobou_pkg::ctrl_reg   seq_ctrl;
  gobou_pkg::ctrl_reg   core_ctrl [gobou_pkg::GOBOU_CORE];
  logic                 seq_img_we;
  gobou_pkg::img_addr_t seq_img_addr;
  gobou_pkg::data_t     seq_img_wdata;
  logic                 img_we;
  gobou_pkg::img_addr_t img_addr;
  gobou_pkg::data_t     img_wdata;
  gobou_pkg::data_t     img_rdata;
  logic [gobou_pkg::GOBOU_CORE-1:0] mem_net_we;
  gobou_pkg::net_addr_t mem_net_addr;
  gobou_pkg::data_t     net_rdata [gobou_pkg::GOBOU_CORE];
  gobou_pkg::core_data_t core_result;
  gobou_pkg::data_t     serial_data;
  logic                 breg_we;
  logic                 serial_we;

  gobou_ctrl_core u_ctrl (
    .clk,
    .xrst,
    .in_ctrl      (core_ctrl[0]),
    .req,
    .net_sel,
    .net_we,
    .net_addr,
    .in_offset,
    .out_offset,
    .total_out,
    .total_in,
    .out_wdata    (serial_data),
    .out_ctrl     (seq_ctrl),
    .ack,
    .img_we       (seq_img_we),
    .img_addr     (seq_img_addr),
    .img_wdata    (seq_img_wdata),
    .mem_net_we,
    .mem_net_addr,
    .breg_we,
    .serial_we
  );

  // ==============================
  // image memory
  // ==============================

  gobou_img_arb u_arb (
    .clk,
    .xrst,
    .busy       (!ack),
    .host_en    (host_img_en),
    .host_we    (host_img_we),
    .host_addr  (host_img_addr),
    .host_wdata (host_img_wdata),
    .seq_we     (seq_img_we),
    .seq_addr   (seq_img_addr),
    .seq_wdata  (seq_img_wdata),
    .host_gnt   (host_img_gnt),
    .mem_we     (img_we),
    .mem_addr   (img_addr),
    .mem_wdata  (img_wdata)
  );

  gobou_mem #(.DEPTH_LOG(gobou_pkg::IMGSIZE), .WIDTH(gobou_pkg::DWIDTH)) u_img_mem (
    .clk,
    .we    (img_we),
    .addr  (img_addr),
    .wdata (img_wdata),
    .rdata (img_rdata)
  );

  assign host_img_rdata = img_rdata;

  // ==============================
  // cores with private weights
  // ==============================

  for (genvar i = 0; i < gobou_pkg::GOBOU_CORE; i++) begin : g_core
    gobou_mem #(.DEPTH_LOG(gobou_pkg::GOBOU_NETSIZE), .WIDTH(gobou_pkg::DWIDTH)) u_net_mem (
      .clk,
      .we    (mem_net_we[i]),
      .addr  (mem_net_addr),
      .wdata (net_wdata),
      .rdata (net_rdata[i])
    );

    gobou_core u_core (
      .clk,
      .xrst,
      .in_ctrl   (seq_ctrl),
      .breg_we,
      .img_rdata,
      .net_rdata (net_rdata[i]),
      .out_ctrl  (core_ctrl[i]),
      .result    (core_result[i])
    );
  end

  gobou_serial u_serial (
    .clk,
    .xrst,
    .serial_we,
    .in_data  (core_result),
    .out_data (serial_data)
  );

endmodule

/* verif/gobou_tb.sv */
`timescale 1ns/1ps

module gobou_tb;

  localparam int          NUM_CASES = 5;
  localparam int          CORES     = gobou_pkg::GOBOU_CORE;
  localparam int          IMG_WORDS = 1 << gobou_pkg::IMGSIZE;
  localparam int          TIMEOUT   = 2000;
  localparam logic [31:0] SEED      = 32'hca75_24f2;

  // geometry of one layer request
  typedef struct packed {
    gobou_pkg::img_addr_t in_offset;
    gobou_pkg::img_addr_t out_offset;
    gobou_pkg::net_addr_t net_offset;
    gobou_pkg::lcount_t   total_in;
    gobou_pkg::lcount_t   total_out;
    logic                 saturate;
  } layer_case_t;

  logic                 clk = 1'b0;
  logic                 xrst;
  logic                 req;
  gobou_pkg::img_addr_t in_offset;
  gobou_pkg::img_addr_t out_offset;
  gobou_pkg::lcount_t   total_in;
  gobou_pkg::lcount_t   total_out;
  logic                 net_we;
  gobou_pkg::core_sel_t net_sel;
  gobou_pkg::net_addr_t net_addr;
  gobou_pkg::data_t     net_wdata;
  logic                 host_img_en;
  logic                 host_img_we;
  gobou_pkg::img_addr_t host_img_addr;
  gobou_pkg::data_t     host_img_wdata;
  logic                 ack;
  logic                 host_img_gnt;
  gobou_pkg::data_t     host_img_rdata;

  layer_case_t      cases [NUM_CASES];
  gobou_pkg::data_t shadow [IMG_WORDS];
  gobou_pkg::data_t in_vec [64];
  gobou_pkg::data_t weight [64][64];
  gobou_pkg::data_t bias [64];

  gobou_top UUT (
    .clk            (clk),
    .xrst           (xrst),
    .req            (req),
    .in_offset      (in_offset),
    .out_offset     (out_offset),
    .total_in       (total_in),
    .total_out      (total_out),
    .net_we         (net_we),
    .net_sel        (net_sel),
    .net_addr       (net_addr),
    .net_wdata      (net_wdata),
    .host_img_en    (host_img_en),
    .host_img_we    (host_img_we),
    .host_img_addr  (host_img_addr),
    .host_img_wdata (host_img_wdata),
    .ack            (ack),
    .host_img_gnt   (host_img_gnt),
    .host_img_rdata (host_img_rdata)
  );

  always #10 clk = ~clk;

  // ==============================
  // checks and waits
  // ==============================

  task automatic check_value(input string name, input logic [gobou_pkg::DWIDTH-1:0] got,
                             input logic [gobou_pkg::DWIDTH-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while (ack !== level && n < TIMEOUT) begin
      n++;
      @(negedge clk);
    end
    if (ack !== level) stop_on_timeout("ack to change");
  endtask

  task automatic wait_grant();
    int n;
    n = 0;
    @(negedge clk);
    while (host_img_gnt !== 1'b1 && n < TIMEOUT) begin
      n++;
      @(negedge clk);
    end
    if (host_img_gnt !== 1'b1) stop_on_timeout("the host image grant");
  endtask

  // ==============================
  // stimulus and reference model
  // ==============================

  // odd multiplier keeps every address bit in the pattern
  function automatic gobou_pkg::data_t fill_word(input int row, input int addr);
    logic [31:0] mix;
    mix = (32'(addr) * 32'h0000_9e37) ^ (32'(row) << 12) ^ 32'h0000_5a5a;
    return gobou_pkg::data_t'(mix[15:0]);
  endfunction

  function automatic gobou_pkg::data_t small_rand(input int span);
    int v;
    v = int'($urandom % span);
    return gobou_pkg::data_t'(v - span / 2);
  endfunction

  // aligned bias plus products, then floor shift and clamp
  function automatic gobou_pkg::data_t neuron_model(input int n, input int fan_in);
    longint sum;
    longint lim;
    int     k;
    lim = longint'(1) << (gobou_pkg::DWIDTH - 1);
    sum = longint'(bias[n]) <<< gobou_pkg::FRAC;
    for (k = 0; k < fan_in; k++) begin
      sum += longint'(in_vec[k]) * longint'(weight[n][k]);
    end
    sum = sum >>> gobou_pkg::FRAC;
    if (sum >= lim) begin
      sum = lim - 1;
    end else if (sum < -lim) begin
      sum = -lim;
    end
    return gobou_pkg::data_t'(sum);
  endfunction

  task automatic make_stimulus(input int row, input layer_case_t lc);
    int a;
    int n;
    int k;
    for (a = 0; a < IMG_WORDS; a++) begin
      shadow[a] = fill_word(row, a);
    end
    for (k = 0; k < int'(lc.total_in); k++) begin
      in_vec[k] = lc.saturate ? gobou_pkg::data_t'(16'h7fff) : small_rand(1024);
      shadow[lc.in_offset + gobou_pkg::img_addr_t'(k)] = in_vec[k];
    end
    for (n = 0; n < int'(lc.total_out); n++) begin
      // even neurons run to the top and odd ones to the bottom
      for (k = 0; k < int'(lc.total_in); k++) begin
        if (lc.saturate) begin
          weight[n][k] = (n % 2 == 0) ? gobou_pkg::data_t'(16'h7fff)
                                      : gobou_pkg::data_t'(16'h8000);
        end else begin
          weight[n][k] = small_rand(512);
        end
      end
      bias[n] = small_rand(2048);
    end
  endtask

  // ==============================
  // host accesses
  // ==============================

  task automatic write_image();
    int a;
    for (a = 0; a < IMG_WORDS; a++) begin
      @(posedge clk);
      host_img_en    <= 1'b1;
      host_img_we    <= 1'b1;
      host_img_addr  <= gobou_pkg::img_addr_t'(a);
      host_img_wdata <= shadow[a];
    end
    @(posedge clk);
    host_img_en <= 1'b0;
    host_img_we <= 1'b0;
  endtask

  // read data trails the address by one cycle
  task automatic compare_image();
    int a;
    for (a = 0; a <= IMG_WORDS; a++) begin
      @(posedge clk);
      host_img_addr <= gobou_pkg::img_addr_t'(a);
      @(negedge clk);
      if (a > 0) begin
        check_value($sformatf("host_img_rdata[%h]", a - 1), host_img_rdata, shadow[a - 1]);
      end
    end
  endtask

  // weights then bias per neuron in one block per group
  task automatic write_nets(input layer_case_t lc);
    int n;
    int k;
    int base;
    for (n = 0; n < int'(lc.total_out); n++) begin
      base = int'(lc.net_offset) + (n / CORES) * (int'(lc.total_in) + 1);
      for (k = 0; k <= int'(lc.total_in); k++) begin
        @(posedge clk);
        net_we    <= 1'b1;
        net_sel   <= gobou_pkg::core_sel_t'(n % CORES);
        net_addr  <= gobou_pkg::net_addr_t'(base + k);
        net_wdata <= (k == int'(lc.total_in)) ? bias[n] : weight[n][k];
      end
    end
    @(posedge clk);
    net_we <= 1'b0;
  endtask

  task automatic run_case(input int row);
    layer_case_t          lc;
    gobou_pkg::img_addr_t guard;
    int                   n;
    lc    = cases[row];
    guard = lc.in_offset + gobou_pkg::img_addr_t'(lc.total_in);
    make_stimulus(row, lc);
    wait_grant();
    write_image();
    compare_image();
    write_nets(lc);
    @(posedge clk);
    req        <= 1'b1;
    in_offset  <= lc.in_offset;
    out_offset <= lc.out_offset;
    total_in   <= lc.total_in;
    total_out  <= lc.total_out;
    net_addr   <= lc.net_offset;
    @(posedge clk);
    req <= 1'b0;
    wait_ack(1'b0);
    // host locked out while the layer runs
    check_value("host_img_gnt", 16'(host_img_gnt), 16'h0);
    @(posedge clk);
    host_img_en    <= 1'b1;
    host_img_we    <= 1'b1;
    host_img_addr  <= guard;
    host_img_wdata <= ~shadow[guard];
    @(posedge clk);
    host_img_en <= 1'b0;
    host_img_we <= 1'b0;
    wait_ack(1'b1);
    wait_grant();
    for (n = 0; n < int'(lc.total_out); n++) begin
      shadow[lc.out_offset + gobou_pkg::img_addr_t'(n)] = neuron_model(n, int'(lc.total_in));
    end
    compare_image();
  endtask

  // ==============================
  // main sequence
  // ==============================

  initial begin
    xrst           = 1'b0;
    req            = 1'b0;
    in_offset      = '0;
    out_offset     = '0;
    total_in       = '0;
    total_out      = '0;
    net_we         = 1'b0;
    net_sel        = '0;
    net_addr       = '0;
    net_wdata      = '0;
    host_img_en    = 1'b0;
    host_img_we    = 1'b0;
    host_img_addr  = '0;
    host_img_wdata = '0;
    void'($urandom(SEED));

    // in_offset, out_offset, net offset, total_in, total_out, saturate
    cases[0] = '{10'h000, 10'h100, 8'h00, 10'd8,  10'd4,  1'b0};
    cases[1] = '{10'h040, 10'h200, 8'h20, 10'd5,  10'd12, 1'b0};
    cases[2] = '{10'h300, 10'h010, 8'h80, 10'd16, 10'd8,  1'b0};
    cases[3] = '{10'h123, 10'h3e0, 8'hc0, 10'd1,  10'd16, 1'b0};
    cases[4] = '{10'h080, 10'h180, 8'h10, 10'd4,  10'd4,  1'b1};

    repeat (3) @(posedge clk);
    xrst <= 1'b1;
    @(negedge clk);
    check_value("ack", 16'(ack), 16'h1);
    check_value("host_img_gnt", 16'(host_img_gnt), 16'h1);

    for (int row = 0; row < NUM_CASES; row++) begin
      run_case(row);
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* gobou_top.f */
design/gobou_pkg.sv
design/gobou_mem.sv
design/gobou_core.sv
design/gobou_serial.sv
design/gobou_img_arb.sv
design/gobou_ctrl_core.sv
design/gobou_top.sv
verif/gobou_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= gobou_tb
RTL_TOP   ?= gobou_top
FILELIST  ?= gobou_top.f
OBJ_DIR   ?= obj_dir
RTL_FILES := $(shell grep '^design/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
